// File: filelist.f
verilog/tlp_rx_pkg.sv
verilog/tlp_rx_parser.sv
verilog/apb_req_fifo.sv
verilog/apb_write_requester.sv
verilog/tlp_rx_top.sv
verif/tlp_rx_tb.sv

// File: verif/tlp_rx_tb.sv
`timescale 1ns/1ps

module tlp_rx_tb;

	localparam int TRACE_RECS = 256;
	localparam int TRACE_WORDS = TRACE_RECS * 4;
	// Bound on the wait for outstanding writes at a test marker
	localparam int DRAIN_LIMIT = 400;
	// Idle cycles after a drain, long enough for a stray write to show up
	localparam int QUIET_CYCLES = 12;

	logic axi_tlp_rx = 1'b0;
	logic arst_n;
	logic tvalid;
	logic [tlp_rx_pkg::TLP_DW_WIDTH-1:0] tdata;
	logic tlast;
	logic tuser;
	logic tready;
	logic psel;
	logic penable;
	logic pwrite;
	logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] paddr;
	logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] pwdata;
	logic pready;

	// Trace records, four words each
	logic [31:0] trace_mem [0:TRACE_WORDS-1];
	// Expected writes in arrival order
	logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] exp_addr_q [$];
	logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] exp_data_q [$];

	integer seed = 32'h477a9684;
	int stall_min = 0;
	int stall_max = 2;
	int stall_left = 0;
	int error_count = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int write_count = 0;
	int beat_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	bit trace_loaded = 1'b0;

	tlp_rx_top UUT (
		.axi_tlp_rx (axi_tlp_rx),
		.arst_n     (arst_n),
		.tvalid     (tvalid),
		.tdata      (tdata),
		.tlast      (tlast),
		.tuser      (tuser),
		.tready     (tready),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.pready     (pready)
	);

	// 4 ns period
	always #2 axi_tlp_rx = ~axi_tlp_rx;

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks, one per result kind

	task automatic check_addr(input string name,
		input logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] exp_val,
		input logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] act_val);
		if (act_val !== exp_val) begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic check_data(input string name,
		input logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] exp_val,
		input logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] act_val);
		if (act_val !== exp_val) begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("Error at %0t: %s expected %b, got %b", $time, name, exp_val, act_val);
			error_count++;
			test_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB completer model

	// Stall count drawn in the setup phase, pready changes 1 ns after the edge
	always @(posedge axi_tlp_rx) begin
		#1;
		if (psel && !penable)
			stall_left = stall_min + ($unsigned($random(seed)) % (stall_max - stall_min + 1));
		else if (penable && stall_left > 0)
			stall_left = stall_left - 1;
		pready = (stall_left == 0);
	end

	// Sampled mid cycle, the transfer completes on the following edge
	always @(negedge axi_tlp_rx) begin
		if (arst_n && psel && penable && pready) begin
			write_count++;
			if (exp_addr_q.size() == 0) begin
				$display("Failure at %0t: APB write to %h with data %h when none was expected",
					$time, paddr, pwdata);
				error_count++;
				test_errors++;
			end else begin
				check_addr("paddr", exp_addr_q.pop_front(), paddr);
				check_data("pwdata", exp_data_q.pop_front(), pwdata);
				check_flag("pwrite", 1'b1, pwrite);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stream driver and test bookkeeping

	// Entered and left 1 ns after a rising edge
	task automatic drive_beat(input logic [31:0] data, input logic last, input logic err,
		input int gap);
		logic accepted;
		repeat (gap) begin
			@(posedge axi_tlp_rx);
			#1;
		end
		tvalid = 1'b1;
		tdata = data;
		tlast = last;
		tuser = err;
		accepted = 1'b0;
		// tready only moves on an edge, so its value here holds up to the next one
		while (!accepted) begin
			accepted = tready;
			@(posedge axi_tlp_rx);
			#1;
		end
		tvalid = 1'b0;
		tlast = 1'b0;
		tuser = 1'b0;
	endtask

	function automatic string test_name(input int id);
		case (id)
			0: return "reset values";
			1: return "config type 0 writes";
			2: return "3DW memory writes";
			3: return "dropped TLPs each followed by a valid one";
			4: return "burst under long pready stalls";
			default: return "unnamed";
		endcase
	endfunction

	task automatic report_test(input int id);
		$display("test %0d %s: %s, %0d error(s)", id, test_name(id),
			(test_errors == 0) ? "pass" : "FAIL", test_errors);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		test_errors = 0;
	endtask

	task automatic finish_test(input int id);
		int waited;
		waited = 0;
		// Wait for queued requests to reach the bus
		while ((exp_addr_q.size() != 0 || psel) && waited < DRAIN_LIMIT) begin
			@(posedge axi_tlp_rx);
			#1;
			waited++;
		end
		repeat (QUIET_CYCLES) @(posedge axi_tlp_rx);
		#1;
		if (exp_addr_q.size() != 0) begin
			$display("Failure at %0t: %0d expected APB write(s) never appeared",
				$time, exp_addr_q.size());
			error_count += exp_addr_q.size();
			test_errors++;
			exp_addr_q.delete();
			exp_data_q.delete();
		end
		report_test(id);
	endtask

	task automatic print_counts();
		$display("tests run %0d, failing %0d, errors %0d, APB writes %0d",
			tests_run, tests_failed, error_count, write_count);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int i;
		int rec;
		logic [31:0] kind;
		logic [31:0] w1;
		logic [31:0] w2;
		logic [31:0] w3;
		arst_n = 1'b0;
		tvalid = 1'b0;
		tdata = '0;
		tlast = 1'b0;
		tuser = 1'b0;
		pready = 1'b1;
		for (i = 0; i < TRACE_WORDS; i++)
			trace_mem[i] = '0;
		$readmemh("verif/tlp_rx_trace.txt", trace_mem);
		for (rec = 0; rec < TRACE_RECS; rec++)
			if (trace_mem[rec * 4] == 32'd1)
				beat_count++;
		if (beat_count == 0) begin
			$display("Failure: trace file holds no stream beats");
			error_count++;
		end
		cycle_limit = 40 * beat_count + 200;
		trace_loaded = 1'b1;

		// Reset held for 8 cycles, outputs checked inside and just after it
		repeat (2) @(posedge axi_tlp_rx);
		#1;
		check_flag("tready", 1'b1, tready);
		check_flag("psel", 1'b0, psel);
		check_flag("penable", 1'b0, penable);
		repeat (6) @(posedge axi_tlp_rx);
		#1;
		arst_n = 1'b1;
		@(posedge axi_tlp_rx);
		#1;
		check_flag("tready", 1'b1, tready);
		check_flag("psel", 1'b0, psel);
		check_flag("penable", 1'b0, penable);
		report_test(0);

		// Walk the trace until the end record
		rec = 0;
		while (rec < TRACE_RECS && trace_mem[rec * 4] != 32'd0) begin
			kind = trace_mem[rec * 4];
			w1 = trace_mem[rec * 4 + 1];
			w2 = trace_mem[rec * 4 + 2];
			w3 = trace_mem[rec * 4 + 3];
			case (kind)
				32'd1: drive_beat(w1, w2[0], w2[1], w3);
				32'd2: begin
					exp_addr_q.push_back(w1[tlp_rx_pkg::APB_ADDR_WIDTH-1:0]);
					exp_data_q.push_back(w2);
				end
				32'd3: finish_test(w1);
				32'd4: begin
					stall_min = w1;
					stall_max = w2;
				end
				default: begin
					$display("Failure: unknown trace record kind %0d at record %0d", kind, rec);
					error_count++;
				end
			endcase
			rec++;
		end

		print_counts();
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Run limit scales with the number of trace beats
	initial begin
		wait (trace_loaded);
		while (cycle_count < cycle_limit) begin
			@(posedge axi_tlp_rx);
			cycle_count++;
		end
		$display("Timeout: run stopped after %0d cycles with the trace unfinished", cycle_count);
		print_counts();
		$display("tests failed");
		$finish;
	end

endmodule

// File: verif/tlp_rx_trace.txt
// Records of four hex words: kind, value, aux, gap. A line may hold several records
// 1 beat: tdata, flags (bit0 tlast, bit1 tuser), idle cycles before the beat
// 2 expected APB write: paddr, pwdata, unused. 3 end of test: test id
// 4 pready stall range in cycles: min, max. 0 end of trace

// Test 1, config type 0 writes, the second one has reserved low bits set
4 0 2 0
2 00000348 11223344 0  1 01000044 0 0  1 0f000010 0 0  1 48030801 0 0  1 11223344 1 0
2 000001fc a5a5a5a5 0  1 01000044 0 2  1 0f000010 0 0  1 ff010200 0 1  1 a5a5a5a5 1 0
3 1 0 0

// Test 2, 3DW memory writes
2 00001a24 55aa00ff 0  1 01000040 0 0  1 0f000010 0 0  1 241adcfe 0 0  1 55aa00ff 1 0
2 00001ffc 0badf00d 0  1 01000040 0 1  1 0f000010 0 0  1 fc0f0000 0 0  1 0badf00d 1 0
3 2 0 0

// Test 3, poisoned memory write
1 01400040 0 0  1 0f000010 0 0  1 241adcfe 0 0  1 deadbeef 1 0
2 00000348 00000001 0  1 01000044 0 0  1 0f000010 0 0  1 48030801 0 0  1 00000001 1 0
// 4DW memory write
1 01000060 0 0  1 0f000010 0 0  1 00000000 0 0  1 241adcfe 0 0  1 deadbeef 1 0
2 00001a24 00000002 0  1 01000040 0 0  1 0f000010 0 0  1 241adcfe 0 0  1 00000002 1 0
// 3DW memory read, no data
1 01000000 0 2  1 0f000010 0 0  1 241adcfe 1 0
2 000001fc 00000003 0  1 01000044 0 0  1 0f000010 0 0  1 ff010200 0 0  1 00000003 1 0
// IO write, a type that is not kept
1 01000042 0 0  1 0f000010 0 0  1 241adcfe 0 0  1 deadbeef 1 0
2 00001ffc 00000004 0  1 01000040 0 0  1 0f000010 0 0  1 fc0f0000 0 0  1 00000004 1 0
// Config write with a CRC error on the data beat
1 01000044 0 0  1 0f000010 0 0  1 48030801 0 0  1 deadbeef 3 0
2 00000348 00000005 0  1 01000044 0 0  1 0f000010 0 0  1 48030801 0 0  1 00000005 1 0
// Data beat without tlast, the TLP ends one beat later
1 01000040 0 0  1 0f000010 0 0  1 241adcfe 0 0  1 deadbeef 0 0  1 deadbeef 1 0
2 00001a24 00000006 0  1 01000040 0 0  1 0f000010 0 0  1 241adcfe 0 0  1 00000006 1 0
3 3 0 0

// Test 4, six back to back writes with 16 to 24 stall cycles each
4 10 18 0
2 00001004 0b000001 0  1 01000040 0 0  1 0f000010 0 0  1 04000000 0 0  1 0b000001 1 0
2 00000004 0b000002 0  1 01000044 0 0  1 0f000010 0 0  1 04000000 0 0  1 0b000002 1 0
2 00001008 0b000003 0  1 01000040 0 0  1 0f000010 0 0  1 08000000 0 0  1 0b000003 1 0
2 00000008 0b000004 0  1 01000044 0 0  1 0f000010 0 0  1 08000000 0 0  1 0b000004 1 0
2 0000100c 0b000005 0  1 01000040 0 0  1 0f000010 0 0  1 0c000000 0 0  1 0b000005 1 0
2 0000000c 0b000006 0  1 01000044 0 0  1 0f000010 0 0  1 0c000000 0 0  1 0b000006 1 0
3 4 0 0
0 0 0 0

// File: verilog/apb_req_fifo.sv
`timescale 1ns/1ps

module apb_req_fifo (
	input  logic                                  axi_tlp_rx,
	input  logic                                  arst_n,
	input  logic                                  push,
	input  logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] push_addr,
	input  logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] push_data,
	input  logic                                  pop,
	output logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] pop_addr,
	output logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] pop_data,
	output logic                                  full,
	output logic                                  empty
);

	// Extra top bit tells a wrapped writer from an equal one
	logic [tlp_rx_pkg::REQ_FIFO_IDX_WIDTH:0] wr_ptr;
	logic [tlp_rx_pkg::REQ_FIFO_IDX_WIDTH:0] rd_ptr;

	// Entry storage
	logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] addr_mem [tlp_rx_pkg::REQ_FIFO_DEPTH];
	logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] data_mem [tlp_rx_pkg::REQ_FIFO_DEPTH];

	logic do_push;
	logic do_pop;

	//////////////////////////////////////////////////////////////////////////
	// Flags

	assign empty = (wr_ptr == rd_ptr);
	// Same index, opposite lap
	assign full = (wr_ptr[tlp_rx_pkg::REQ_FIFO_IDX_WIDTH] !=
		rd_ptr[tlp_rx_pkg::REQ_FIFO_IDX_WIDTH]) &&
		(wr_ptr[tlp_rx_pkg::REQ_FIFO_IDX_WIDTH-1:0] ==
		rd_ptr[tlp_rx_pkg::REQ_FIFO_IDX_WIDTH-1:0]);

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Head entry, valid whenever not empty
	assign pop_addr = addr_mem[rd_ptr[tlp_rx_pkg::REQ_FIFO_IDX_WIDTH-1:0]];
	assign pop_data = data_mem[rd_ptr[tlp_rx_pkg::REQ_FIFO_IDX_WIDTH-1:0]];

	//////////////////////////////////////////////////////////////////////////
	// Pointers and storage

	always_ff @(posedge axi_tlp_rx or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge axi_tlp_rx) begin
		if (do_push) begin
			addr_mem[wr_ptr[tlp_rx_pkg::REQ_FIFO_IDX_WIDTH-1:0]] <= push_addr;
			data_mem[wr_ptr[tlp_rx_pkg::REQ_FIFO_IDX_WIDTH-1:0]] <= push_data;
		end
	end

	// Requester only pops a real entry
	assert property (@(posedge axi_tlp_rx) disable iff (!arst_n)
		pop |-> !empty);

	// Parser never overruns the queue
	assert property (@(posedge axi_tlp_rx) disable iff (!arst_n)
		push |-> !full);

endmodule

// File: verilog/apb_write_requester.sv
`timescale 1ns/1ps

module apb_write_requester (
	input  logic                                  axi_tlp_rx,
	input  logic                                  arst_n,
	input  logic                                  empty,
	output logic                                  pop,
	input  logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] pop_addr,
	input  logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] pop_data,
	output logic                                  psel,
	output logic                                  penable,
	output logic                                  pwrite,
	output logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] paddr,
	output logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] pwdata,
	input  logic                                  pready
);

	logic [1:0] state;

	// Take the head as soon as we are free
	assign pop = (state == tlp_rx_pkg::APB_ST_IDLE) && !empty;

	// Write only, no read path
	assign pwrite = psel;

	//////////////////////////////////////////////////////////////////////////
	// Transfer sequencing

	// Bus strobes move with the phase
	always_ff @(posedge axi_tlp_rx or negedge arst_n) begin
		if (!arst_n) begin
			state <= tlp_rx_pkg::APB_ST_IDLE;
			psel <= 1'b0;
			penable <= 1'b0;
		end else begin
			case (state)
				tlp_rx_pkg::APB_ST_IDLE: begin
					if (!empty) begin
						state <= tlp_rx_pkg::APB_ST_SETUP;
						psel <= 1'b1;
					end
				end
				// Setup phase lasts exactly one cycle
				tlp_rx_pkg::APB_ST_SETUP: begin
					state <= tlp_rx_pkg::APB_ST_ACCESS;
					penable <= 1'b1;
				end
				tlp_rx_pkg::APB_ST_ACCESS: begin
					// Completer may stretch this
					if (pready) begin
						state <= tlp_rx_pkg::APB_ST_IDLE;
						psel <= 1'b0;
						penable <= 1'b0;
					end
				end
				default: begin
					state <= tlp_rx_pkg::APB_ST_IDLE;
					psel <= 1'b0;
					penable <= 1'b0;
				end
			endcase
		end
	end

	// Latch the popped entry and hold it to the end of the transfer
	always_ff @(posedge axi_tlp_rx) begin
		if (pop) begin
			paddr <= pop_addr;
			pwdata <= pop_data;
		end
	end

	assert property (@(posedge axi_tlp_rx) disable iff (!arst_n)
		penable |-> psel);

	// Address and data frozen until the completer accepts
	assert property (@(posedge axi_tlp_rx) disable iff (!arst_n)
		(psel && !(penable && pready)) |=> ($stable(paddr) && $stable(pwdata)));

endmodule

// File: verilog/tlp_rx_parser.sv
`timescale 1ns/1ps

module tlp_rx_parser (
	input  logic                                  axi_tlp_rx,
	input  logic                                  arst_n,
	input  logic                                  tvalid,
	input  logic [tlp_rx_pkg::TLP_DW_WIDTH-1:0]   tdata,
	input  logic                                  tlast,
	input  logic                                  tuser,
	output logic                                  tready,
	input  logic                                  full,
	output logic                                  push,
	output logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] push_addr,
	output logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] push_data
);

	logic [2:0] state;
	logic beat;

	// Header word 0 fields, in stream byte order
	logic [2:0] hdr_fmt;
	logic [4:0] hdr_type;
	logic [tlp_rx_pkg::TLP_LEN_WIDTH-1:0] hdr_len;
	logic fmt_ok;
	logic type_ok;
	logic hdr_keep;

	// Held from header word 0 until the data beat
	logic hdr_cfg;
	tlp_rx_pkg::tlp_addr_dw_u addr_dw;

	//////////////////////////////////////////////////////////////////////////
	// Stream handshake

	// Stall the link only while the queue has no room
	assign tready = !full;
	assign beat = tvalid && tready;

	//////////////////////////////////////////////////////////////////////////
	// Header word 0 decode

	assign hdr_fmt = tdata[7:5];
	assign hdr_type = tdata[4:0];
	// Length is split across two bytes
	assign hdr_len = {tdata[17:16], tdata[31:24]};

	always_comb begin
		case (hdr_fmt)
			// Only 3DW with payload is handled
			tlp_rx_pkg::TLP_FMT_3DW_DATA: fmt_ok = 1'b1;
			// Reads have no payload
			tlp_rx_pkg::TLP_FMT_3DW_NODATA: fmt_ok = 1'b0;
			tlp_rx_pkg::TLP_FMT_4DW_NODATA: fmt_ok = 1'b0;
			// No 64-bit addressing
			tlp_rx_pkg::TLP_FMT_4DW_DATA: fmt_ok = 1'b0;
			default: fmt_ok = 1'b0;
		endcase
	end

	assign type_ok = (hdr_type == tlp_rx_pkg::TLP_TYPE_MEM) ||
		(hdr_type == tlp_rx_pkg::TLP_TYPE_CFG0);

	// Poisoned or multi-word TLPs are dropped here too
	assign hdr_keep = fmt_ok && type_ok && !tdata[tlp_rx_pkg::TLP_POISON_BIT] &&
		(hdr_len == 10'd1);

	//////////////////////////////////////////////////////////////////////////
	// State machine and push strobe

	always_ff @(posedge axi_tlp_rx or negedge arst_n) begin
		if (!arst_n) begin
			state <= tlp_rx_pkg::RX_ST_IDLE;
			push <= 1'b0;
		end else begin
			// Single cycle strobe
			push <= 1'b0;
			if (beat) begin
				case (state)
					tlp_rx_pkg::RX_ST_IDLE: begin
						if (hdr_keep)
							state <= tlp_rx_pkg::RX_ST_HDR1;
						else
							state <= tlp_rx_pkg::RX_ST_DROP;
					end
					// Requester ID, tag and byte enables are ignored
					tlp_rx_pkg::RX_ST_HDR1: state <= tlp_rx_pkg::RX_ST_HDR2;
					tlp_rx_pkg::RX_ST_HDR2: state <= tlp_rx_pkg::RX_ST_DATA;
					tlp_rx_pkg::RX_ST_DATA: begin
						// Anything after the data word is malformed
						state <= tlp_rx_pkg::RX_ST_DROP;
						// Good CRC on the only data word
						if (tlast && !tuser)
							push <= 1'b1;
					end
					// Drop, and stray codes, wait for the end of the TLP
					default: state <= tlp_rx_pkg::RX_ST_DROP;
				endcase

				// End of any TLP goes back to idle
				if (tlast)
					state <= tlp_rx_pkg::RX_ST_IDLE;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Captured fields and request payload

	always_ff @(posedge axi_tlp_rx) begin
		if (beat) begin
			if (state == tlp_rx_pkg::RX_ST_IDLE)
				hdr_cfg <= (hdr_type == tlp_rx_pkg::TLP_TYPE_CFG0);

			// Address word arrives byte swapped
			if (state == tlp_rx_pkg::RX_ST_HDR2)
				addr_dw <= {tdata[7:0], tdata[15:8], tdata[23:16], tdata[31:24]};

			if (state == tlp_rx_pkg::RX_ST_DATA) begin
				push_data <= tdata;
				// Config space is dword addressed by register number
				if (hdr_cfg)
					push_addr <= {tlp_rx_pkg::APB_SPACE_CFG, addr_dw.cfg.ext_reg_num,
						addr_dw.cfg.reg_num, 2'b00};
				else
					push_addr <= {tlp_rx_pkg::APB_SPACE_MEM, addr_dw.mem[11:0]};
			end
		end
	end

	// Queue is never offered a request it cannot take
	assert property (@(posedge axi_tlp_rx) disable iff (!arst_n)
		push |-> !full);

endmodule

// File: verilog/tlp_rx_pkg.sv
package tlp_rx_pkg;

	//////////////////////////////////////////////////////////////////////////
	// TLP header fields

	// Stream word and header length field widths
	localparam int TLP_DW_WIDTH = 32;
	localparam int TLP_LEN_WIDTH = 10;

	// Format codes from header word 0
	localparam logic [2:0] TLP_FMT_3DW_NODATA = 3'd0;
	localparam logic [2:0] TLP_FMT_4DW_NODATA = 3'd1;
	localparam logic [2:0] TLP_FMT_3DW_DATA = 3'd2;
	localparam logic [2:0] TLP_FMT_4DW_DATA = 3'd3;

	// Type codes, only these two are ever kept
	localparam logic [4:0] TLP_TYPE_MEM = 5'd0;
	localparam logic [4:0] TLP_TYPE_CFG0 = 5'd4;

	// Poisoned flag in header word 0
	localparam int TLP_POISON_BIT = 22;

	//////////////////////////////////////////////////////////////////////////
	// APB side and request queue

	localparam int APB_ADDR_WIDTH = 13;
	localparam int APB_DATA_WIDTH = 32;

	// Top paddr bit selects the address space
	localparam logic APB_SPACE_CFG = 1'b0;
	localparam logic APB_SPACE_MEM = 1'b1;

	localparam int REQ_FIFO_DEPTH = 4;
	localparam int REQ_FIFO_IDX_WIDTH = $clog2(REQ_FIFO_DEPTH);

	// Parser states
	localparam logic [2:0] RX_ST_IDLE = 3'd0;
	localparam logic [2:0] RX_ST_HDR1 = 3'd1;
	localparam logic [2:0] RX_ST_HDR2 = 3'd2;
	localparam logic [2:0] RX_ST_DATA = 3'd3;
	localparam logic [2:0] RX_ST_DROP = 3'd4;

	// Requester states
	localparam logic [1:0] APB_ST_IDLE = 2'd0;
	localparam logic [1:0] APB_ST_SETUP = 2'd1;
	localparam logic [1:0] APB_ST_ACCESS = 2'd2;

	// Third header word after byte swap
	// Config target view or plain memory address view
	typedef union packed {
		struct packed {
			logic [7:0] bus_num;
			logic [4:0] dev_num;
			logic [2:0] func_num;
			logic [3:0] rsvd_hi;
			logic [3:0] ext_reg_num;
			logic [5:0] reg_num;
			logic [1:0] rsvd_lo;
		} cfg;
		logic [31:0] mem;
	} tlp_addr_dw_u;

endpackage

// File: verilog/tlp_rx_top.sv
`timescale 1ns/1ps

module tlp_rx_top (
	input  logic                                  axi_tlp_rx,
	input  logic                                  arst_n,
	input  logic                                  tvalid,
	input  logic [tlp_rx_pkg::TLP_DW_WIDTH-1:0]   tdata,
	input  logic                                  tlast,
	input  logic                                  tuser,
	output logic                                  tready,
	output logic                                  psel,
	output logic                                  penable,
	output logic                                  pwrite,
	output logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] paddr,
	output logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] pwdata,
	input  logic                                  pready
);

	// Parser to queue
	logic push;
	logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] push_addr;
	logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] push_data;
	logic full;

	// Queue to requester
	logic empty;
	logic pop;
	logic [tlp_rx_pkg::APB_ADDR_WIDTH-1:0] pop_addr;
	logic [tlp_rx_pkg::APB_DATA_WIDTH-1:0] pop_data;

	//////////////////////////////////////////////////////////////////////////
	// Parser, request queue, APB requester

	tlp_rx_parser parser (
		.axi_tlp_rx (axi_tlp_rx),
		.arst_n     (arst_n),
		.tvalid     (tvalid),
		.tdata      (tdata),
		.tlast      (tlast),
		.tuser      (tuser),
		.tready     (tready),
		.full       (full),
		.push       (push),
		.push_addr  (push_addr),
		.push_data  (push_data)
	);

	apb_req_fifo req_fifo (
		.axi_tlp_rx (axi_tlp_rx),
		.arst_n     (arst_n),
		.push       (push),
		.push_addr  (push_addr),
		.push_data  (push_data),
		.pop        (pop),
		.pop_addr   (pop_addr),
		.pop_data   (pop_data),
		.full       (full),
		.empty      (empty)
	);

	apb_write_requester requester (
		.axi_tlp_rx (axi_tlp_rx),
		.arst_n     (arst_n),
		.empty      (empty),
		.pop        (pop),
		.pop_addr   (pop_addr),
		.pop_data   (pop_data),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.pready     (pready)
	);

endmodule
